//--- include/qspi_xip_defs.svh
// widths, register offsets, reset defaults, version word
// and segment FIFO depth of the serial flash read controller.
`ifndef QSPI_XIP_DEFS_SVH
`define QSPI_XIP_DEFS_SVH

`define QX_ADDR_W 32
`define QX_DATA_W 32

// config register byte offsets.
`define QX_REG_VERSION   8'h00
`define QX_REG_CLKDIV    8'h04
`define QX_REG_ADDR_MASK 8'h08
`define QX_REG_CMD_CFG   8'h0C

`define QX_VERSION 32'hAC210824

`define QX_RST_CLKDIV    8'd1
`define QX_RST_ADDR_MASK 32'h000FFFFF
`define QX_RST_READ_CMD  8'h03
`define QX_RST_DUMMY     4'd0
`define QX_RST_ADDR4     1'b0

// worst case read is five segments.
`define QX_SEG_DEPTH 8

`endif

//--- design/qspi_xip_pkg.sv
// sequencer state enum, bus segment opcode enum and segment FIFO entry.
`default_nettype none

package qspi_xip_pkg;

  typedef enum logic [1:0] {
    SEG_TX    = 2'd0,  // send len bytes, msb first.
    SEG_DUMMY = 2'd1,  // len clocks, data ignored.
    SEG_RX    = 2'd2,  // receive one word.
    SEG_DESEL = 2'd3   // raise chip select.
  } seg_op_e;

  typedef struct packed {
    seg_op_e     op;
    logic [3:0]  len;
    logic [31:0] data;
  } seg_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_DESEL,
    SEQ_CMD,
    SEQ_ADDR,
    SEQ_DUMMY,
    SEQ_DATA
  } seq_state_e;

endpackage

`default_nettype wire

//--- design/qspi_cfg_regs.sv
// configuration register slave with clock divider, address mask and
// read command setup, behind valid/ready write and read channels.
`timescale 1ns/1ns
`default_nettype none
`include "qspi_xip_defs.svh"

module qspi_cfg_regs (
  input  wire                   aclk,
  input  wire                   arstn,
  input  wire  [7:0]            cfg_aw_addr_i,
  input  wire                   cfg_aw_valid_i,
  input  wire  [`QX_DATA_W-1:0] cfg_w_data_i,
  input  wire                   cfg_w_valid_i,
  output logic                  cfg_aw_ready_o,
  output logic                  cfg_w_ready_o,
  output logic                  cfg_b_valid_o,
  input  wire                   cfg_b_ready_i,
  input  wire  [7:0]            cfg_ar_addr_i,
  input  wire                   cfg_ar_valid_i,
  output logic                  cfg_ar_ready_o,
  output logic [`QX_DATA_W-1:0] cfg_r_data_o,
  output logic                  cfg_r_valid_o,
  input  wire                   cfg_r_ready_i,
  output logic [7:0]            clkdiv_o,
  output logic [`QX_ADDR_W-1:0] addr_mask_o,
  output logic [7:0]            read_cmd_o,
  output logic [3:0]            dummy_len_o,
  output logic                  addr4_o
);

  logic                  wr_fire;
  logic                  rd_fire;
  logic [`QX_DATA_W-1:0] rd_mux;

  // address and data are taken in the same cycle.
  assign cfg_aw_ready_o = cfg_aw_valid_i & cfg_w_valid_i & ~cfg_b_valid_o;
  assign cfg_w_ready_o  = cfg_aw_ready_o;
  assign wr_fire        = cfg_aw_ready_o;
  assign cfg_ar_ready_o = ~cfg_r_valid_o;
  assign rd_fire        = cfg_ar_valid_i & cfg_ar_ready_o;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      clkdiv_o    <= `QX_RST_CLKDIV;
      addr_mask_o <= `QX_RST_ADDR_MASK;
      read_cmd_o  <= `QX_RST_READ_CMD;
      dummy_len_o <= `QX_RST_DUMMY;
      addr4_o     <= `QX_RST_ADDR4;
    end else if (wr_fire) begin
      case (cfg_aw_addr_i)
        `QX_REG_CLKDIV:    clkdiv_o    <= cfg_w_data_i[7:0];
        `QX_REG_ADDR_MASK: addr_mask_o <= cfg_w_data_i;
        `QX_REG_CMD_CFG: begin
          dummy_len_o <= cfg_w_data_i[31:28];
          addr4_o     <= cfg_w_data_i[24];
          read_cmd_o  <= cfg_w_data_i[7:0];
        end
        default: ;  // version and unknown offsets.
      endcase
    end
  end

  always_comb begin
    case (cfg_ar_addr_i)
      `QX_REG_VERSION:   rd_mux = `QX_VERSION;
      `QX_REG_CLKDIV:    rd_mux = {24'h000000, clkdiv_o};
      `QX_REG_ADDR_MASK: rd_mux = addr_mask_o;
      `QX_REG_CMD_CFG:   rd_mux = {dummy_len_o, 3'b000, addr4_o, 16'h0000, read_cmd_o};
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      cfg_b_valid_o <= 1'b0;
      cfg_r_valid_o <= 1'b0;
    end else begin
      if (wr_fire)
        cfg_b_valid_o <= 1'b1;
      else if (cfg_b_ready_i)
        cfg_b_valid_o <= 1'b0;
      if (rd_fire)
        cfg_r_valid_o <= 1'b1;
      else if (cfg_r_ready_i)
        cfg_r_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_fire)
      cfg_r_data_o <= rd_mux;
  end

endmodule

`default_nettype wire

//--- design/qspi_read_seq.sv
// read sequencer that turns memory reads into bus segments,
// keeping chip select low across sequential word reads.
`timescale 1ns/1ns
`default_nettype none
`include "qspi_xip_defs.svh"

module qspi_read_seq
  import qspi_xip_pkg::*;
(
  input  wire                   aclk,
  input  wire                   arstn,
  input  wire  [`QX_ADDR_W-1:0] ar_addr_i,
  input  wire                   ar_valid_i,
  output logic                  ar_ready_o,
  input  wire  [`QX_ADDR_W-1:0] addr_mask_i,
  input  wire  [7:0]            read_cmd_i,
  input  wire  [3:0]            dummy_len_i,
  input  wire                   addr4_i,
  output seg_t                  seg_o,
  output logic                  seg_push_o,
  input  wire  [3:0]            seg_free_i
);

  localparam logic [3:0] MAX_SEGS = 4'd5;

  seq_state_e            state_q;
  logic                  run_q;
  logic                  sel_q;
  logic [`QX_ADDR_W-1:0] next_addr_q;
  logic [`QX_ADDR_W-1:0] waddr_q;
  logic [`QX_ADDR_W-1:0] req_addr;
  logic                  accept;
  logic                  hit;

  assign req_addr   = {ar_addr_i[`QX_ADDR_W-1:2], 2'b00} & addr_mask_i;
  // room for a whole sequence is reserved up front.
  assign ar_ready_o = run_q & (state_q == SEQ_IDLE) & (seg_free_i >= MAX_SEGS);
  assign accept     = ar_valid_i & ar_ready_o;
  assign hit        = sel_q & (req_addr == next_addr_q);

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      state_q     <= SEQ_IDLE;
      run_q       <= 1'b0;
      sel_q       <= 1'b0;
      next_addr_q <= '0;
    end else begin
      run_q <= 1'b1;
      case (state_q)
        SEQ_IDLE: begin
          if (accept) begin
            sel_q       <= 1'b1;
            next_addr_q <= req_addr + `QX_ADDR_W'(4);
            if (hit)
              state_q <= SEQ_DATA;  // flash keeps streaming.
            else if (sel_q)
              state_q <= SEQ_DESEL;
            else
              state_q <= SEQ_CMD;
          end
        end
        SEQ_DESEL: state_q <= SEQ_CMD;
        SEQ_CMD:   state_q <= SEQ_ADDR;
        SEQ_ADDR:  state_q <= (dummy_len_i != 4'd0) ? SEQ_DUMMY : SEQ_DATA;
        SEQ_DUMMY: state_q <= SEQ_DATA;
        SEQ_DATA:  state_q <= SEQ_IDLE;
        default:   state_q <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept)
      waddr_q <= req_addr;
  end

  // one segment per state after the accept.
  always_comb begin
    seg_o      = '{op: SEG_DESEL, len: 4'd0, data: 32'h0};
    seg_push_o = 1'b1;
    case (state_q)
      SEQ_DESEL: ;
      SEQ_CMD: begin
        seg_o.op   = SEG_TX;
        seg_o.len  = 4'd1;
        seg_o.data = {24'h000000, read_cmd_i};
      end
      SEQ_ADDR: begin
        seg_o.op   = SEG_TX;
        seg_o.len  = addr4_i ? 4'd4 : 4'd3;
        seg_o.data = waddr_q;  // low bytes only for 3-byte mode.
      end
      SEQ_DUMMY: begin
        seg_o.op  = SEG_DUMMY;
        seg_o.len = dummy_len_i;
      end
      SEQ_DATA: begin
        seg_o.op  = SEG_RX;
        seg_o.len = 4'd4;
      end
      default: seg_push_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/qspi_seg_fifo.sv
// synchronous FIFO of bus segments with a free entry count.
`timescale 1ns/1ns
`default_nettype none
`include "qspi_xip_defs.svh"

module qspi_seg_fifo
  import qspi_xip_pkg::*;
(
  input  wire        aclk,
  input  wire        arstn,
  input  wire        push_i,
  input  wire  seg_t push_data_i,
  output logic [3:0] free_o,
  input  wire        pop_i,
  output seg_t       pop_data_o,
  output logic       empty_o
);

  localparam int PTR_W = $clog2(`QX_SEG_DEPTH);
  localparam int CNT_W = $clog2(`QX_SEG_DEPTH + 1);

  seg_t             mem_q [`QX_SEG_DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o    = (count_q == '0);
  assign free_o     = 4'(`QX_SEG_DEPTH - count_q);
  assign do_push    = push_i & (count_q != CNT_W'(`QX_SEG_DEPTH));
  assign do_pop     = pop_i & ~empty_o;
  assign pop_data_o = mem_q[rptr_q];

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push)
        wptr_q <= (wptr_q == PTR_W'(`QX_SEG_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      if (do_pop)
        rptr_q <= (rptr_q == PTR_W'(`QX_SEG_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (do_push)
      mem_q[wptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

//--- design/qspi_shift_engine.sv
// segment executor driving SPI mode 0 clock, chip select and data,
// with a half period divider and little-endian read word assembly.
`timescale 1ns/1ns
`default_nettype none

module qspi_shift_engine
  import qspi_xip_pkg::*;
(
  input  wire         aclk,
  input  wire         arstn,
  input  wire  [7:0]  clkdiv_i,
  input  wire  seg_t  seg_i,
  input  wire         seg_empty_i,
  output logic        seg_pop_o,
  output logic [31:0] r_data_o,
  output logic        r_valid_o,
  input  wire         r_ready_i,
  output logic        sck_o,
  output logic        csb_o,
  output logic        mosi_o,
  input  wire         miso_i
);

  seg_op_e     op_q;
  logic        busy_q;
  logic [5:0]  cnt_q;  // bits, dummy clocks or half periods.
  logic [7:0]  div_q;
  logic [31:0] tx_sh_q;
  logic [31:0] rx_sh_q;
  logic [31:0] tx_load;
  logic [5:0]  cnt_load;
  logic        tick;
  logic        edge_en;
  logic        rise;
  logic        fall;
  logic        last;
  logic        rx_done;

  // nothing new starts while a read word waits.
  assign seg_pop_o = ~seg_empty_i & ~busy_q & ~r_valid_o;
  assign tick      = busy_q & (div_q >= clkdiv_i);
  assign edge_en   = tick & (op_q != SEG_DESEL);
  assign rise      = edge_en & ~sck_o;
  assign fall      = edge_en & sck_o;
  assign last      = (cnt_q == 6'd1);
  assign rx_done   = fall & last & (op_q == SEG_RX);
  // left align the len low bytes.
  assign tx_load   = seg_i.data << {3'd4 - seg_i.len[2:0], 3'b000};

  always_comb begin
    case (seg_i.op)
      SEG_TX:    cnt_load = {seg_i.len[2:0], 3'b000};
      SEG_DUMMY: cnt_load = {2'b00, seg_i.len};
      SEG_RX:    cnt_load = 6'd32;
      default:   cnt_load = 6'd2;  // two half periods high.
    endcase
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      busy_q    <= 1'b0;
      op_q      <= SEG_DESEL;
      cnt_q     <= '0;
      div_q     <= '0;
      sck_o     <= 1'b0;
      csb_o     <= 1'b1;
      mosi_o    <= 1'b0;
      r_valid_o <= 1'b0;
    end else begin
      if (r_valid_o && r_ready_i)
        r_valid_o <= 1'b0;
      if (seg_pop_o) begin
        busy_q <= 1'b1;
        op_q   <= seg_i.op;
        cnt_q  <= cnt_load;
        div_q  <= '0;
        csb_o  <= (seg_i.op == SEG_DESEL);
        mosi_o <= (seg_i.op == SEG_TX) & tx_load[31];  // first bit before first rise.
      end else if (busy_q) begin
        div_q <= tick ? '0 : div_q + 1'b1;
        if (tick && op_q == SEG_DESEL) begin
          cnt_q <= cnt_q - 1'b1;
          if (last)
            busy_q <= 1'b0;
        end
        if (rise)
          sck_o <= 1'b1;
        if (fall) begin
          sck_o  <= 1'b0;
          mosi_o <= tx_sh_q[30];
          cnt_q  <= cnt_q - 1'b1;
          if (last)
            busy_q <= 1'b0;
        end
        if (rx_done)
          r_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (seg_pop_o)
      tx_sh_q <= (seg_i.op == SEG_TX) ? tx_load : '0;
    else if (fall)
      tx_sh_q <= {tx_sh_q[30:0], 1'b0};
    if (rise)
      rx_sh_q <= {rx_sh_q[30:0], miso_i};
    if (rx_done)
      r_data_o <= {rx_sh_q[7:0], rx_sh_q[15:8], rx_sh_q[23:16], rx_sh_q[31:24]};
  end

endmodule

`default_nettype wire

//--- design/qspi_xip_top.sv
// top level connecting config registers, read sequencer, segment FIFO and shift engine.
`timescale 1ns/1ns
`default_nettype none

module qspi_xip_top
  import qspi_xip_pkg::*;
(
  input  wire         aclk,
  input  wire         arstn,
  input  wire  [31:0] ar_addr_i,
  input  wire         ar_valid_i,
  output logic        ar_ready_o,
  output logic [31:0] r_data_o,
  output logic        r_valid_o,
  input  wire         r_ready_i,
  input  wire  [7:0]  cfg_aw_addr_i,
  input  wire         cfg_aw_valid_i,
  input  wire  [31:0] cfg_w_data_i,
  input  wire         cfg_w_valid_i,
  output logic        cfg_aw_ready_o,
  output logic        cfg_w_ready_o,
  output logic        cfg_b_valid_o,
  input  wire         cfg_b_ready_i,
  input  wire  [7:0]  cfg_ar_addr_i,
  input  wire         cfg_ar_valid_i,
  output logic        cfg_ar_ready_o,
  output logic [31:0] cfg_r_data_o,
  output logic        cfg_r_valid_o,
  input  wire         cfg_r_ready_i,
  output logic        sck_o,
  output logic        csb_o,
  output logic        mosi_o,
  input  wire         miso_i
);

  logic [7:0]  clkdiv;
  logic [31:0] addr_mask;
  logic [7:0]  read_cmd;
  logic [3:0]  dummy_len;
  logic        addr4;
  seg_t        seg_wdata;
  seg_t        seg_rdata;
  logic        seg_push;
  logic        seg_pop;
  logic        seg_empty;
  logic [3:0]  seg_free;

  qspi_cfg_regs i_qspi_cfg_regs (
    .aclk, .arstn,
    .cfg_aw_addr_i, .cfg_aw_valid_i, .cfg_w_data_i, .cfg_w_valid_i,
    .cfg_aw_ready_o, .cfg_w_ready_o, .cfg_b_valid_o, .cfg_b_ready_i,
    .cfg_ar_addr_i, .cfg_ar_valid_i, .cfg_ar_ready_o,
    .cfg_r_data_o, .cfg_r_valid_o, .cfg_r_ready_i,
    .clkdiv_o(clkdiv), .addr_mask_o(addr_mask), .read_cmd_o(read_cmd),
    .dummy_len_o(dummy_len), .addr4_o(addr4)
  );

  qspi_read_seq i_qspi_read_seq (
    .aclk, .arstn,
    .ar_addr_i, .ar_valid_i, .ar_ready_o,
    .addr_mask_i(addr_mask), .read_cmd_i(read_cmd), .dummy_len_i(dummy_len),
    .addr4_i(addr4),
    .seg_o(seg_wdata), .seg_push_o(seg_push), .seg_free_i(seg_free)
  );

  qspi_seg_fifo i_qspi_seg_fifo (
    .aclk, .arstn,
    .push_i(seg_push), .push_data_i(seg_wdata), .free_o(seg_free),
    .pop_i(seg_pop), .pop_data_o(seg_rdata), .empty_o(seg_empty)
  );

  qspi_shift_engine i_qspi_shift_engine (
    .aclk, .arstn,
    .clkdiv_i(clkdiv),
    .seg_i(seg_rdata), .seg_empty_i(seg_empty), .seg_pop_o(seg_pop),
    .r_data_o, .r_valid_o, .r_ready_i,
    .sck_o, .csb_o, .mosi_o, .miso_i
  );

endmodule

`default_nettype wire

//--- verification/spi_flash_model.sv
// behavioural SPI NOR flash for mode 0 reads, answering opcodes 03 and 0B
// with a byte pattern computed from the address.
`timescale 1ns/1ns
`default_nettype none

module spi_flash_model (
  input  wire        sck_i,
  input  wire        csb_i,
  input  wire        mosi_i,
  output logic       miso_o,
  input  wire        addr4_i,
  input  wire  [3:0] dummy_i,
  output int         cmd_count_o,
  output int         desel_count_o
);

  logic [7:0]  cmd_q;
  logic [31:0] addr_q;
  logic [7:0]  cur_byte;
  int          phase;  // 0 opcode, 1 address, 2 dummy, 3 data.
  int          bit_n;

  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  initial begin
    miso_o        = 1'b0;
    cmd_count_o   = 0;
    desel_count_o = 0;
    cmd_q         = 8'h00;
    addr_q        = 32'h0;
    phase         = 0;
    bit_n         = 0;
  end

  // mosi is sampled on the rising edge.
  always @(posedge sck_i or posedge csb_i) begin
    if (csb_i) begin
      phase         = 0;
      bit_n         = 0;
      desel_count_o = desel_count_o + 1;
    end else begin
      bit_n = bit_n + 1;
      case (phase)
        0: begin
          cmd_q = {cmd_q[6:0], mosi_i};
          if (bit_n == 8) begin
            cmd_count_o = cmd_count_o + 1;
            addr_q      = 32'h0;
            phase       = 1;
            bit_n       = 0;
          end
        end
        1: begin
          addr_q = {addr_q[30:0], mosi_i};
          if (bit_n == (addr4_i ? 32 : 24)) begin
            phase = (dummy_i != 4'd0) ? 2 : 3;
            bit_n = 0;
          end
        end
        2: begin
          if (bit_n == int'(dummy_i)) begin
            phase = 3;
            bit_n = 0;
          end
        end
        default: begin
          if (bit_n == 8) begin
            addr_q = addr_q + 32'd1;  // stream on while selected.
            bit_n  = 0;
          end
        end
      endcase
    end
  end

  // miso changes on the falling edge.
  always @(negedge sck_i) begin
    if (!csb_i && phase == 3 && (cmd_q == 8'h03 || cmd_q == 8'h0B)) begin
      cur_byte = pattern_byte(addr_q);
      miso_o <= cur_byte[3'(7 - bit_n)];
    end
  end

endmodule

`default_nettype wire

//--- verification/qspi_xip_tb.sv
// testbench for the serial flash read controller with clock, reset, golden file
// stimulus, read back-pressure from an xorshift generator, checks and timeout.
`timescale 1ns/1ns
`default_nettype none
`include "qspi_xip_defs.svh"

module qspi_xip_tb;

  localparam string GOLDEN_FILE     = "verification/qspi_xip_golden.txt";
  localparam int    CYCLES_PER_LINE = 400;

  logic        aclk;
  logic        arstn;
  logic [31:0] ar_addr;
  logic        ar_valid;
  logic        ar_ready;
  logic [31:0] r_data;
  logic        r_valid;
  logic        r_ready;
  logic [7:0]  cfg_aw_addr;
  logic        cfg_aw_valid;
  logic [31:0] cfg_w_data;
  logic        cfg_w_valid;
  logic        cfg_aw_ready;
  logic        cfg_w_ready;
  logic        cfg_b_valid;
  logic        cfg_b_ready;
  logic [7:0]  cfg_ar_addr;
  logic        cfg_ar_valid;
  logic        cfg_ar_ready;
  logic [31:0] cfg_r_data;
  logic        cfg_r_valid;
  logic        cfg_r_ready;
  logic        sck;
  logic        csb;
  logic        mosi;
  logic        miso;
  logic        flash_addr4;
  logic [3:0]  flash_dummy;
  int          cmd_count;
  int          desel_count;
  logic [31:0] cur_mask;
  logic [31:0] rng_state;
  string       line_tag [$];
  logic [31:0] line_a [$];
  logic [31:0] line_b [$];
  logic [31:0] exp_words [$];
  int          cycle_count = 0;
  int          cycle_limit = 0;

  qspi_xip_top i_qspi_xip_top (
    .aclk(aclk), .arstn(arstn),
    .ar_addr_i(ar_addr), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_data_o(r_data), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .cfg_aw_addr_i(cfg_aw_addr), .cfg_aw_valid_i(cfg_aw_valid),
    .cfg_w_data_i(cfg_w_data), .cfg_w_valid_i(cfg_w_valid),
    .cfg_aw_ready_o(cfg_aw_ready), .cfg_w_ready_o(cfg_w_ready),
    .cfg_b_valid_o(cfg_b_valid), .cfg_b_ready_i(cfg_b_ready),
    .cfg_ar_addr_i(cfg_ar_addr), .cfg_ar_valid_i(cfg_ar_valid),
    .cfg_ar_ready_o(cfg_ar_ready),
    .cfg_r_data_o(cfg_r_data), .cfg_r_valid_o(cfg_r_valid), .cfg_r_ready_i(cfg_r_ready),
    .sck_o(sck), .csb_o(csb), .mosi_o(mosi), .miso_i(miso)
  );

  spi_flash_model i_spi_flash_model (
    .sck_i(sck), .csb_i(csb), .mosi_i(mosi), .miso_o(miso),
    .addr4_i(flash_addr4), .dummy_i(flash_dummy),
    .cmd_count_o(cmd_count), .desel_count_o(desel_count)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      abort_run($sformatf("mismatch at %0t ns: %s expected %h got %h",
                          $time, name, expected, actual));
  endtask

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // little-endian word built from the flash byte pattern.
  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [31:0] w;
    logic [31:0] b;
    int          k;
    for (k = 0; k < 4; k++) begin
      b = a + 32'(k);
      w[8*k +: 8] = b[7:0] ^ b[15:8] ^ 8'h5A;
    end
    return w;
  endfunction

  task automatic cfg_write(input logic [7:0] offset, input logic [31:0] data);
    cfg_aw_addr  = offset;
    cfg_w_data   = data;
    cfg_aw_valid = 1'b1;
    cfg_w_valid  = 1'b1;
    do @(posedge aclk); while (!(cfg_aw_ready && cfg_w_ready));
    #1;
    cfg_aw_valid = 1'b0;
    cfg_w_valid  = 1'b0;
    cfg_b_ready  = 1'b1;
    do @(posedge aclk); while (!cfg_b_valid);
    #1;
    cfg_b_ready = 1'b0;
  endtask

  task automatic cfg_read(input logic [7:0] offset, input logic [31:0] expected);
    cfg_ar_addr  = offset;
    cfg_ar_valid = 1'b1;
    do @(posedge aclk); while (!cfg_ar_ready);
    #1;
    cfg_ar_valid = 1'b0;
    cfg_r_ready  = 1'b1;
    do @(posedge aclk); while (!cfg_r_valid);
    check_value("cfg_r_data_o", expected, cfg_r_data);
    #1;
    cfg_r_ready = 1'b0;
  endtask

  task automatic issue_reads(input logic [31:0] addr, input int count);
    int i;
    for (i = 0; i < count; i++) begin
      ar_addr  = addr + 32'(4 * i);
      ar_valid = 1'b1;
      do @(posedge aclk); while (!ar_ready);
      #1;
      ar_valid = 1'b0;
    end
  endtask

  task automatic collect_reads(input int count);
    int i;
    int stall;
    for (i = 0; i < count; i++) begin
      stall = int'(next_random() & 32'h7);  // r_ready held low first.
      repeat (stall) begin
        @(posedge aclk);
        #1;
      end
      r_ready = 1'b1;
      do @(posedge aclk); while (!r_valid);
      check_value("r_data_o", exp_words.pop_front(), r_data);
      #1;
      r_ready = 1'b0;
    end
  endtask

  task automatic mem_read(input logic [31:0] addr, input logic [31:0] expected);
    exp_words.push_back(expected);
    fork
      issue_reads(addr, 1);
      collect_reads(1);
    join
  endtask

  // the rest of the burst must not reselect the flash or resend the opcode.
  task automatic run_burst(input logic [31:0] addr, input int count);
    int i;
    int cmd_before;
    int desel_before;
    for (i = 0; i < count; i++)
      exp_words.push_back(word_at((addr + 32'(4 * i)) & cur_mask & 32'hFFFFFFFC));
    fork
      issue_reads(addr, 1);
      collect_reads(1);
    join
    cmd_before   = cmd_count;
    desel_before = desel_count;
    fork
      issue_reads(addr + 32'd4, count - 1);
      collect_reads(count - 1);
    join
    check_value("flash opcode count", 32'(cmd_before), 32'(cmd_count));
    check_value("flash deselect count", 32'(desel_before), 32'(desel_count));
  endtask

  initial begin
    int          fd;
    int          n;
    int          i;
    string       tag;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    arstn        = 1'b0;
    ar_addr      = 32'h0;
    ar_valid     = 1'b0;
    r_ready      = 1'b0;
    cfg_aw_addr  = 8'h00;
    cfg_aw_valid = 1'b0;
    cfg_w_data   = 32'h0;
    cfg_w_valid  = 1'b0;
    cfg_b_ready  = 1'b0;
    cfg_ar_addr  = 8'h00;
    cfg_ar_valid = 1'b0;
    cfg_r_ready  = 1'b0;
    flash_addr4  = 1'b0;
    flash_dummy  = 4'd0;
    cur_mask     = `QX_RST_ADDR_MASK;
    rng_state    = 32'h3f53;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0)
      abort_run("could not open the golden stimulus file");
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tag);
      if (n == 1) begin
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2)
            abort_run("golden file line is missing its two values");
          line_tag.push_back(tag);
          line_a.push_back(a);
          line_b.push_back(b);
        end
      end
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_LINE * line_tag.size();
    repeat (3) @(posedge aclk);
    #1;
    arstn = 1'b1;
    check_value("csb_o", 32'd1, 32'(csb));
    check_value("sck_o", 32'd0, 32'(sck));
    check_value("mosi_o", 32'd0, 32'(mosi));
    check_value("r_valid_o", 32'd0, 32'(r_valid));
    check_value("ar_ready_o", 32'd0, 32'(ar_ready));
    check_value("cfg_b_valid_o", 32'd0, 32'(cfg_b_valid));
    check_value("cfg_r_valid_o", 32'd0, 32'(cfg_r_valid));
    for (i = 0; i < line_tag.size(); i++) begin
      if (line_tag[i] == "W") begin
        cfg_write(line_a[i][7:0], line_b[i]);
        if (line_a[i][7:0] == `QX_REG_CMD_CFG) begin
          flash_addr4 = line_b[i][24];
          flash_dummy = line_b[i][31:28];
        end
        if (line_a[i][7:0] == `QX_REG_ADDR_MASK)
          cur_mask = line_b[i];
      end else if (line_tag[i] == "R") begin
        cfg_read(line_a[i][7:0], line_b[i]);
      end else if (line_tag[i] == "M") begin
        mem_read(line_a[i], line_b[i]);
      end else if (line_tag[i] == "P") begin
        run_burst(line_a[i], int'(line_b[i]));
      end else begin
        abort_run($sformatf("unknown command %s in the golden file", line_tag[i]));
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/qspi_xip_golden.txt
# tag  offset/address  data/expected/count
# W config write, R config read, M memory read, P sequential burst of count words
R 00 AC210824
R 04 00000001
R 08 000FFFFF
R 0C 00000003
R 10 00000000
W 00 12345678
R 00 AC210824
W 10 DEADBEEF
R 10 00000000
M 1234567B 77767574
W 08 FFFFFFFF
R 08 FFFFFFFF
W 0C 8100000B
R 0C 8100000B
M A5003000 69686B6A
P 00002000 6
M 00000040 19181B1A
W 0C 00000003
W 04 00000003
R 04 00000003
P 0001FFF8 5
M 00ABCDEF 78797A7B

//--- qspi_xip.f
+incdir+include
design/qspi_xip_pkg.sv
design/qspi_cfg_regs.sv
design/qspi_read_seq.sv
design/qspi_seg_fifo.sv
design/qspi_shift_engine.sv
design/qspi_xip_top.sv
verification/spi_flash_model.sv
verification/qspi_xip_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = qspi_xip_tb
FILELIST = qspi_xip.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
